// File: src/afpm_params.svh
/* Field widths and constants for the approximate FP16 log multiplier.
   Values are fixed by the FP16 format; only the antilog offset is tunable */
`ifndef AFPM_PARAMS_SVH
`define AFPM_PARAMS_SVH

// FP16 word layout
`define AFPM_HALF_W 16
`define AFPM_EXP_W 5
`define AFPM_MANT_W 10

// Log mantissa keeps one carry bit above the fraction
`define AFPM_LOG_W 11

`define AFPM_EXP_BIAS 15 // Standard FP16 bias

// Added in the upper antilog segment, 0b1101 << 6
`define AFPM_ANTILOG_OFFSET 832

`endif

// File: src/afpm_pkg.sv
/* Shared types for the log multiplier. Widths come from the params header */
package afpm_pkg;

	`include "afpm_params.svh"

	// Packed FP16 word, sign at the top
	typedef logic [`AFPM_HALF_W-1:0] half_t;

	typedef logic [`AFPM_EXP_W-1:0] exp_t; // Biased exponent

	// Linear mantissa, also used for a log fraction
	typedef logic [`AFPM_MANT_W-1:0] mant_t;

	typedef logic [`AFPM_LOG_W-1:0] logm_t; // Log value with carry bit

	typedef logic [7:0] byte_t; // One pad bus byte

	// I/O controller states
	typedef enum logic [1:0] {
		IDLE,        // Wait for a nonzero start byte
		COLLECT,     // Low then high operand bytes
		WAIT_RESULT, // Core busy
		SEND         // High result byte
	} io_state_t;

endpackage

// File: src/fp_operands_if.sv
/* Unpacked operand fields from the I/O controller to the core.
   Fields are only meaningful in the cycle where valid is high */
`timescale 1ns/1ps

interface fp_operands_if
	import afpm_pkg::*;
();

	logic  valid; // Single-cycle pulse

	// Operand A
	logic  sa;
	exp_t  ea;
	mant_t ma;

	// Operand B
	logic  sb;
	exp_t  eb;
	mant_t mb;

	modport ctrl (
		output valid, sa, ea, ma, sb, eb, mb
	);

	modport core (
		input valid, sa, ea, ma, sb, eb, mb
	);

endinterface

// File: src/log_mant_approx.sv
/* Piecewise log2 of a 10-bit mantissa, four shift-and-add segments.
   The result is truncated to 10 bits, so bit 10 of lm is always zero */
`timescale 1ns/1ps
`include "afpm_params.svh"

module log_mant_approx
	import afpm_pkg::*;
(
	input  mant_t m,
	output logm_t lm
);

	mant_t seg_sum; // Truncated segment value

	// Top two mantissa bits pick the slope of the segment
	always_comb begin
		unique case (m[`AFPM_MANT_W-1 -: 2])
			2'b11: begin
				seg_sum = m + (m >> 5); // Flattest part of the curve
			end
			2'b10: begin
				seg_sum = m + (m >> 3);
			end
			2'b01: begin
				seg_sum = m + (m >> 2);
			end
			default: begin
				seg_sum = m + (m >> 2) + (m >> 4); // Steepest, near 1.0
			end
		endcase
	end

	// Zero extend, the carry bit only fills in the core adder
	assign lm = {1'b0, seg_sum};

endmodule

// File: src/antilog_mant_approx.sv
/* Two-segment antilog of a 10-bit log fraction back to a linear mantissa.
   Output wraps at 10 bits, no rounding */
`timescale 1ns/1ps
`include "afpm_params.svh"

module antilog_mant_approx
	import afpm_pkg::*;
(
	input  mant_t f,
	output mant_t m
);

	mant_t upper_seg; // f >= 0.5
	mant_t lower_seg; // f < 0.5

	// Upper half of the fraction range, slope about 1.2 plus offset
	always_comb begin
		upper_seg = f + (f >> 3) + (f >> 5) + (f >> 6)
			+ mant_t'(`AFPM_ANTILOG_OFFSET);
	end

	// Lower half, slope about 0.8
	always_comb begin
		lower_seg = (f >> 1) + (f >> 2) + (f >> 4);
	end

	// Bit 9 of the fraction splits the two segments
	always_comb begin
		if (f[`AFPM_MANT_W-1]) begin
			m = upper_seg;
		end else begin
			m = lower_seg;
		end
	end

endmodule

// File: src/log_mult_core.sv
/* Four-stage log multiply pipeline, fixed latency of 4 cycles, no stall.
   No special-value handling; the exponent wraps modulo 32 */
`timescale 1ns/1ps
`include "afpm_params.svh"

module log_mult_core
	import afpm_pkg::*;
(
	input  logic              clk,
	input  logic              rst_n,
	fp_operands_if.core       ops,
	output logic              res_valid,
	output half_t             result
);

	// Combinational approximation outputs
	logm_t lma;
	logm_t lmb;
	mant_t antilog_m;

	// Stage valid bits, res_valid is the fourth
	logic  v1;
	logic  v2;
	logic  v3;

	// Stage 1
	logic  s1_sign;
	exp_t  s1_ea;
	exp_t  s1_eb;
	logm_t s1_lma;
	logm_t s1_lmb;

	// Stage 2
	logic  s2_sign;
	exp_t  s2_exp;  // ea + eb - bias, before the carry
	logm_t s2_sum;

	// Stage 3
	logic  s3_sign;
	exp_t  s3_exp;
	mant_t s3_mant;

	log_mant_approx u_log_a (
		.m  (ops.ma),
		.lm (lma)
	);

	log_mant_approx u_log_b (
		.m  (ops.mb),
		.lm (lmb)
	);

	// Fraction part of the log sum
	antilog_mant_approx u_antilog (
		.f (s2_sum[`AFPM_MANT_W-1:0]),
		.m (antilog_m)
	);

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			v1        <= 1'b0;
			v2        <= 1'b0;
			v3        <= 1'b0;
			res_valid <= 1'b0;
		end else begin
			v1        <= ops.valid;
			v2        <= v1;
			v3        <= v2;
			res_valid <= v3;
		end
	end

	// Datapath advances every cycle, the valid bits mark live entries
	always_ff @(posedge clk) begin
		s1_sign <= ops.sa ^ ops.sb;
		s1_ea   <= ops.ea;
		s1_eb   <= ops.eb;
		s1_lma  <= lma;
		s1_lmb  <= lmb;

		s2_sign <= s1_sign;
		s2_exp  <= s1_ea + s1_eb - exp_t'(`AFPM_EXP_BIAS);
		s2_sum  <= s1_lma + s1_lmb; // Bit 10 is the carry

		s3_sign <= s2_sign;
		s3_exp  <= s2_exp + exp_t'(s2_sum[`AFPM_LOG_W-1]); // Log carry bumps exponent
		s3_mant <= antilog_m;

		result  <= {s3_sign, s3_exp, s3_mant};
	end

	// Fixed latency, the controller relies on it
	a_latency: assert property (@(posedge clk) disable iff (!rst_n)
		res_valid == $past(ops.valid, 4));

endmodule

// File: src/afpm_io_ctrl.sv
/* Byte framing for the multiplier: start on nonzero ui_in, low bytes first.
   One operation at a time; bus inputs are ignored while busy */
`timescale 1ns/1ps
`include "afpm_params.svh"

module afpm_io_ctrl
	import afpm_pkg::*;
(
	input  logic         clk,
	input  logic         rst_n,
	input  byte_t        ui_in,
	input  byte_t        uio_in,
	input  logic         res_valid,
	input  half_t        result,
	output byte_t        uo_out,
	fp_operands_if.ctrl  ops
);

	io_state_t state;
	logic      byte_idx; // 0 for low byte, 1 for high byte

	byte_t     a_lo;
	byte_t     b_lo;
	byte_t     res_hi;   // Held for the second output cycle

	half_t     a_word;
	half_t     b_word;

	logic      take_lo;
	logic      take_hi;
	logic      take_res;

	// Full operand words once the high byte is on the bus
	assign a_word = {ui_in, a_lo};
	assign b_word = {uio_in, b_lo};

	assign take_lo  = (state == COLLECT) && !byte_idx;
	assign take_hi  = (state == COLLECT) && byte_idx;
	assign take_res = (state == WAIT_RESULT) && res_valid;

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			state     <= IDLE;
			byte_idx  <= 1'b0;
			ops.valid <= 1'b0;
			uo_out    <= '0;
		end else begin
			ops.valid <= 1'b0; // Pulse by default
			case (state)
				IDLE: begin
					byte_idx <= 1'b0;
					if (ui_in != '0) begin
						state <= COLLECT; // Any nonzero byte is a start
					end
				end
				COLLECT: begin
					byte_idx <= ~byte_idx;
					if (byte_idx) begin
						ops.valid <= 1'b1;
						state     <= WAIT_RESULT;
					end
				end
				WAIT_RESULT: begin
					if (res_valid) begin
						uo_out <= result[7:0];
						state  <= SEND;
					end
				end
				SEND: begin
					uo_out <= res_hi; // Stays on the bus afterwards
					state  <= IDLE;
				end
				default: begin
					state <= IDLE;
				end
			endcase
		end
	end

	// Operand and result bytes
	always_ff @(posedge clk) begin
		if (take_lo) begin
			a_lo <= ui_in;
			b_lo <= uio_in;
		end
		if (take_hi) begin
			ops.sa <= a_word[`AFPM_HALF_W-1];
			ops.ea <= a_word[`AFPM_HALF_W-2 -: `AFPM_EXP_W];
			ops.ma <= a_word[`AFPM_MANT_W-1:0];
			ops.sb <= b_word[`AFPM_HALF_W-1];
			ops.eb <= b_word[`AFPM_HALF_W-2 -: `AFPM_EXP_W];
			ops.mb <= b_word[`AFPM_MANT_W-1:0];
		end
		if (take_res) begin
			res_hi <= result[15:8];
		end
	end

	// One operation in flight at a time
	a_valid_pulse: assert property (@(posedge clk) disable iff (!rst_n)
		ops.valid |=> !ops.valid);

	// Core result must line up with the wait state
	a_res_in_wait: assert property (@(posedge clk) disable iff (!rst_n)
		res_valid |-> state == WAIT_RESULT);

endmodule

// File: src/log_afpm_top.sv
/* Top level of the byte-serial approximate FP16 multiplier.
   Product appears on uo_out 7 and 8 cycles after the start byte */
`timescale 1ns/1ps

module log_afpm_top
	import afpm_pkg::*;
(
	input  logic  clk,
	input  logic  rst_n,
	input  byte_t ui_in,  // Operand A bytes, start byte first
	input  byte_t uio_in, // Operand B bytes
	output byte_t uo_out  // Product, low byte first
);

	logic  res_valid;
	half_t result;

	// Unpacked operands, controller to core
	fp_operands_if ops_if ();

	afpm_io_ctrl u_io_ctrl (
		.clk       (clk),
		.rst_n     (rst_n),
		.ui_in     (ui_in),
		.uio_in    (uio_in),
		.res_valid (res_valid),
		.result    (result),
		.uo_out    (uo_out),
		.ops       (ops_if.ctrl)
	);

	log_mult_core u_core (
		.clk       (clk),
		.rst_n     (rst_n),
		.ops       (ops_if.core),
		.res_valid (res_valid),
		.result    (result)
	);

endmodule

// File: verification/tb_clock_gen.sv
/* Free-running testbench clock, starts low.
   Period must be an even number of ns */
`timescale 1ns/1ps

module tb_clock_gen #(
	parameter int period_ns = 4
) (
	output logic clk
);

	initial begin
		clk = 1'b0;
		forever begin
			#(period_ns / 2) clk = ~clk; // Half period per toggle
		end
	end

endmodule

// File: verification/tb_log_afpm.sv
/* Self-checking testbench for the byte-serial FP16 log multiplier.
   Inputs change on falling edges; uo_out is checked 7 and 8 edges after the start */
`timescale 1ns/1ps
`include "afpm_params.svh"

module tb_log_afpm
	import afpm_pkg::*;
();

	localparam int period_ns  = 4;
	localparam int num_dir    = 8;
	localparam int num_sign   = 4;
	localparam int num_carry  = 3;
	localparam int num_random = 200;
	localparam int num_busy   = 4;
	localparam int num_ops    = num_dir + num_sign + num_carry + num_random + num_busy;
	localparam int watchdog_ns = num_ops * 12 * period_ns + 50 * period_ns; // Plus reset margin
	localparam byte_t start_byte = 8'h5a;

	logic   clk;
	logic   rst_n;
	byte_t  ui_in;
	byte_t  uio_in;
	byte_t  uo_out;

	integer seed = 7523;
	int     value_errors = 0;
	int     other_errors = 0;
	logic   expect_zero = 1'b0; // uo_out must read 0
	logic   out_window = 1'b0;  // uo_out may change

	// Directed pairs, one mantissa from each log segment
	half_t dir_a [num_dir] = '{16'h3c00, 16'h3f80, 16'h3e80, 16'h3d55,
		16'h3c40, 16'h3f80, 16'h3d55, 16'h4400};
	half_t dir_b [num_dir] = '{16'h3c00, 16'h3c00, 16'h3c00, 16'h3c00,
		16'h3c00, 16'h3e80, 16'h3c40, 16'h3a10};
	half_t sign_a [num_sign] = '{16'h4000, 16'hc000, 16'h4000, 16'hc000};
	half_t sign_b [num_sign] = '{16'h4200, 16'h4200, 16'hc200, 16'hc200};
	// Log sums of these pairs reach bit 10
	half_t carry_a [num_carry] = '{16'h3e00, 16'h3b00, 16'h4700};
	half_t carry_b [num_carry] = '{16'h3e00, 16'h3f00, 16'h3e80};

	tb_clock_gen #(.period_ns(period_ns)) u_clk_gen (.clk(clk));

	log_afpm_top dut (
		.clk    (clk),
		.rst_n  (rst_n),
		.ui_in  (ui_in),
		.uio_in (uio_in),
		.uo_out (uo_out)
	);

	// Piecewise log of a mantissa
	function automatic logic [10:0] ref_log(input logic [9:0] m);
		logic [9:0] t;
		case (m[9:8])
			2'b11: t = m + (m >> 5);
			2'b10: t = m + (m >> 3);
			2'b01: t = m + (m >> 2);
			default: t = m + (m >> 2) + (m >> 4);
		endcase
		return {1'b0, t};
	endfunction

	function automatic logic [9:0] ref_antilog(input logic [9:0] f);
		if (f[9]) begin
			return f + (f >> 3) + (f >> 5) + (f >> 6) + 10'(`AFPM_ANTILOG_OFFSET);
		end
		return (f >> 1) + (f >> 2) + (f >> 4);
	endfunction

	function automatic half_t model_product(input half_t a, input half_t b);
		logic [10:0] s;
		logic [4:0]  e;
		s = ref_log(a[9:0]) + ref_log(b[9:0]);
		e = a[14:10] + b[14:10] - 5'(`AFPM_EXP_BIAS) + {4'b0, s[10]}; // Wraps mod 32
		return {a[15] ^ b[15], e, ref_antilog(s[9:0])};
	endfunction

	// Bus contents while the DUT is busy
	task automatic drive_idle(input bit noisy);
		if (noisy) begin
			ui_in  = byte_t'($random(seed));
			uio_in = byte_t'($random(seed));
		end else begin
			ui_in  = '0;
			uio_in = '0;
		end
	endtask

	// Called on a falling edge, returns on the falling edge before the next start
	task automatic run_op(input half_t a, input half_t b, input bit noisy, output half_t got);
		half_t exp_word;
		exp_word   = model_product(a, b);
		out_window = 1'b0;
		ui_in      = start_byte;
		uio_in     = '0;
		@(negedge clk);
		ui_in  = a[7:0];
		uio_in = b[7:0];
		@(negedge clk);
		ui_in  = a[15:8];
		uio_in = b[15:8];
		repeat (6) begin
			@(negedge clk);
			drive_idle(noisy);
		end
		out_window = 1'b1; // Low byte landed at E0+7
		got[7:0]   = uo_out;
		assert (uo_out == exp_word[7:0]) else begin
			value_errors++;
			$display("error: uo_out low byte 0x%02h, expected 0x%02h (a 0x%04h, b 0x%04h)",
				uo_out, exp_word[7:0], a, b);
		end
		@(negedge clk);
		drive_idle(1'b0);
		got[15:8] = uo_out;
		assert (uo_out == exp_word[15:8]) else begin
			value_errors++;
			$display("error: uo_out high byte 0x%02h, expected 0x%02h (a 0x%04h, b 0x%04h)",
				uo_out, exp_word[15:8], a, b);
		end
		@(negedge clk);
	endtask

	a_idle_zero: assert property (@(posedge clk) disable iff (!rst_n)
		expect_zero |-> uo_out == 8'h00)
		else begin
			value_errors++;
			$display("error: uo_out 0x%02h while idle, expected 0x00", $sampled(uo_out));
		end

	// Output must hold outside the two result cycles
	a_out_hold: assert property (@(posedge clk) disable iff (!rst_n)
		!out_window |-> $stable(uo_out))
		else begin
			other_errors++;
			$display("uo_out changed outside the result window, now 0x%02h", $sampled(uo_out));
		end

	initial begin
		#(watchdog_ns);
		$display("Timeout after %0d ns, the run did not complete", watchdog_ns);
		$display("Verification failed");
		$finish;
	end

	initial begin
		half_t a;
		half_t b;
		half_t got;
		rst_n  = 1'b0;
		ui_in  = '0;
		uio_in = '0;
		repeat (4) @(negedge clk);
		rst_n       = 1'b1;
		expect_zero = 1'b1;
		repeat (10) begin
			uio_in = byte_t'($random(seed)); // B bus alone is no start
			@(negedge clk);
		end
		expect_zero = 1'b0;
		uio_in      = '0;

		for (int i = 0; i < num_dir; i++) begin
			run_op(dir_a[i], dir_b[i], 1'b0, got);
		end
		for (int i = 0; i < num_sign; i++) begin
			run_op(sign_a[i], sign_b[i], 1'b0, got);
			assert (got[15] == (sign_a[i][15] ^ sign_b[i][15])) else begin
				value_errors++;
				$display("error: uo_out sign 0x%01h, expected 0x%01h",
					got[15], sign_a[i][15] ^ sign_b[i][15]);
			end
		end
		for (int i = 0; i < num_carry; i++) begin
			run_op(carry_a[i], carry_b[i], 1'b0, got);
			// One above ea + eb - 15
			assert (got[14:10] == carry_a[i][14:10] + carry_b[i][14:10] - 5'd14) else begin
				value_errors++;
				$display("error: uo_out exponent 0x%02h, expected 0x%02h", got[14:10],
					5'(carry_a[i][14:10] + carry_b[i][14:10] - 5'd14));
			end
		end
		for (int i = 0; i < num_random; i++) begin
			a = half_t'($random(seed));
			b = half_t'($random(seed));
			run_op(a, b, 1'b0, got);
		end
		for (int i = 0; i < num_busy; i++) begin
			a = half_t'($random(seed));
			b = half_t'($random(seed));
			run_op(a, b, 1'b1, got); // Bus noise while busy
		end
		out_window = 1'b0;
		repeat (4) @(negedge clk);

		$display("Checks done: %0d value errors, %0d other errors", value_errors, other_errors);
		if (value_errors == 0 && other_errors == 0) begin
			$display("Verification passed");
		end else begin
			$display("Verification failed");
		end
		$finish;
	end

endmodule

// File: tb.f
+incdir+src
src/afpm_pkg.sv
src/fp_operands_if.sv
src/log_mant_approx.sv
src/antilog_mant_approx.sv
src/log_mult_core.sv
src/afpm_io_ctrl.sv
src/log_afpm_top.sv
verification/tb_clock_gen.sv
verification/tb_log_afpm.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Builds the testbench with Verilator and runs it.
# Exit status is 0 only when the pass message shows up in the output.
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ps \
	-f tb.f --top-module tb_log_afpm \
	&& ./obj_dir/Vtb_log_afpm | tee /dev/stderr | grep -x "Verification passed" > /dev/null \
	&& echo "Simulation run passed" \
	|| { echo "Simulation run failed"; exit 1; }
